/* source/histo_macros.svh */
`ifndef HISTO_MACROS_SVH
`define HISTO_MACROS_SVH

// raw timestamp width from the TDC front end
`define SAMPLE_W 10

// bin = top BIN_W bits of a timestamp
`define BIN_W 4
`define NBINS (1 << `BIN_W)

// per-bin counter, saturating
`define COUNT_W 8

// frame geometry
`define PIXEL_NUM 4
`define ACQ_NUM 8
// samples per pixel per acquisition
`define DATA_NUM 40
`define FRAME_LEN (`PIXEL_NUM * `ACQ_NUM * `DATA_NUM)

// address = {pixel, bin}
`define ADDR_W ($clog2(`PIXEL_NUM) + `BIN_W)
`define MEM_DEPTH (`PIXEL_NUM * `NBINS)

`endif

/* source/histPkg.sv */
`include "histo_macros.svh"

package histPkg;

    // controller phases, CLEAR is the post-reset memory sweep
    typedef enum logic [2:0] {
        CLEAR,
        IDLE,
        ACCUM,
        DRAIN,
        SCAN
    } seqState;

    typedef logic [`BIN_W-1:0] binT;
    typedef logic [`COUNT_W-1:0] countT;
    // pixel index, upper field of the address
    typedef logic [`ADDR_W-`BIN_W-1:0] pixT;
    // {pixel, bin}
    typedef logic [`ADDR_W-1:0] addrT;

endpackage

/* source/memPort.sv */
`timescale 1ns/1ns

// one read port plus one write port into the histogram memory
interface memPort;
    import histPkg::*;

    // read side, rdata one cycle after rEn
    logic rEn;
    addrT raddr;
    countT rdata;

    // write side
    logic wEn;
    addrT waddr;
    countT wdata;

    modport client (
        output rEn, raddr, wEn, waddr, wdata,
        input rdata
    );

    modport memory (
        input rEn, raddr, wEn, waddr, wdata,
        output rdata
    );

endinterface

/* source/histRam.sv */
`timescale 1ns/1ns
`include "histo_macros.svh"

module histRam (
    input logic clk,
    input logic rst,
    input logic scanSel,
    output logic ramReady,
    memPort.memory acc,
    memPort.memory scan
);
    import histPkg::*;

    countT mem [`MEM_DEPTH];
    countT rdata;

    // clear sweep state
    logic clearing;
    addrT clrAddr;

    // selected client
    logic rEnSel;
    logic wEnSel;
    addrT rAddrSel;
    addrT wAddrSel;
    countT wDataSel;

    // scan owns the memory for the whole SCAN phase
    assign rEnSel = scanSel ? scan.rEn : acc.rEn;
    assign rAddrSel = scanSel ? scan.raddr : acc.raddr;
    assign wEnSel = scanSel ? scan.wEn : acc.wEn;
    assign wAddrSel = scanSel ? scan.waddr : acc.waddr;
    assign wDataSel = scanSel ? scan.wdata : acc.wdata;

    // both clients see the same read data
    assign acc.rdata = rdata;
    assign scan.rdata = rdata;

    assign ramReady = ~clearing;

    // one word per cycle, PIXEL_NUM*NBINS cycles total
    always_ff @(posedge clk) begin
        if (rst) begin
            clearing <= 1'b1;
            clrAddr <= '0;
        end else if (clearing) begin
            clrAddr <= clrAddr + 1'b1;
            if (clrAddr == addrT'(`MEM_DEPTH - 1)) begin
                clearing <= 1'b0;
            end
        end
    end

    // read-first, a write shows up on the next cycle's read
    always_ff @(posedge clk) begin
        if (clearing) begin
            mem[clrAddr] <= '0;
        end else if (wEnSel) begin
            mem[wAddrSel] <= wDataSel;
        end
        if (rEnSel) begin
            rdata <= mem[rAddrSel];
        end
    end

endmodule

/* source/binUpdater.sv */
`timescale 1ns/1ns

module binUpdater (
    input logic clk,
    input logic rst,
    input logic updValid,
    input histPkg::addrT updAddr,
    output logic updIdle,
    memPort.client mem
);
    import histPkg::*;

    // stage 1: read data returning
    logic s1Valid;
    addrT s1Addr;

    // stage 2: incremented count being written
    logic s2Valid;
    addrT s2Addr;
    countT s2Count;

    // last cycle's write, memory read in stage 0 missed it
    logic s3Valid;
    addrT s3Addr;
    countT s3Count;

    countT baseCount;
    countT incCount;

    // stage 0 issues the read
    assign mem.rEn = updValid;
    assign mem.raddr = updAddr;

    // stage 2 writes back
    assign mem.wEn = s2Valid;
    assign mem.waddr = s2Addr;
    assign mem.wdata = s2Count;

    // nothing in flight, all writes landed
    assign updIdle = ~(updValid | s1Valid | s2Valid);

    // forwarding, newest write wins
    always_comb begin
        if (s2Valid && (s2Addr == s1Addr)) begin
            baseCount = s2Count;
        end else if (s3Valid && (s3Addr == s1Addr)) begin
            baseCount = s3Count;
        end else begin
            baseCount = mem.rdata;
        end
    end

    // saturate at all ones
    assign incCount = (baseCount == '1) ? baseCount : baseCount + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
            s3Valid <= 1'b0;
        end else begin
            s1Valid <= updValid;
            s2Valid <= s1Valid;
            s3Valid <= s2Valid;
        end
    end

    // payload pipe
    always_ff @(posedge clk) begin
        s1Addr <= updAddr;
        s2Addr <= s1Addr;
        s2Count <= incCount;
        s3Addr <= s2Addr;
        s3Count <= s2Count;
    end

endmodule

/* source/peakFinder.sv */
`timescale 1ns/1ns
`include "histo_macros.svh"

module peakFinder (
    input logic clk,
    input logic rst,
    input logic scanStart,
    output logic scanDone,
    output logic peakValid,
    output histPkg::pixT peakPixel,
    output histPkg::binT peakBin,
    output histPkg::countT peakCount,
    memPort.client mem
);
    import histPkg::*;

    // read address walk over all pixels
    logic scanning;
    addrT scanAddr;

    // address whose data is on rdata this cycle
    logic rdValid;
    addrT rdAddr;

    // running peak of the current pixel
    countT bestCount;
    binT bestBin;

    binT curBin;
    pixT curPix;
    logic takeNew;
    countT newCount;
    binT newBin;

    assign mem.rEn = scanning;
    assign mem.raddr = scanAddr;

    // read-and-clear, zero goes back one cycle after the read
    assign mem.wEn = rdValid;
    assign mem.waddr = rdAddr;
    assign mem.wdata = '0;

    assign curBin = rdAddr[`BIN_W-1:0];
    assign curPix = rdAddr[`ADDR_W-1:`BIN_W];

    // bin 0 restarts the peak, strict compare keeps the lower bin on ties
    assign takeNew = (curBin == '0) || (mem.rdata > bestCount);
    assign newCount = takeNew ? mem.rdata : bestCount;
    assign newBin = takeNew ? curBin : bestBin;

    always_ff @(posedge clk) begin
        if (rst) begin
            scanning <= 1'b0;
            scanAddr <= '0;
            rdValid <= 1'b0;
            peakValid <= 1'b0;
            scanDone <= 1'b0;
        end else begin
            if (scanStart) begin
                scanning <= 1'b1;
                scanAddr <= '0;
            end else if (scanning) begin
                scanAddr <= scanAddr + 1'b1;
                if (scanAddr == addrT'(`MEM_DEPTH - 1)) begin
                    scanning <= 1'b0;
                end
            end
            rdValid <= scanning;
            // one strobe per pixel on its last bin
            peakValid <= rdValid && (curBin == '1);
            // done right after the last pixel's strobe
            scanDone <= peakValid && (peakPixel == pixT'(`PIXEL_NUM - 1));
        end
    end

    always_ff @(posedge clk) begin
        rdAddr <= scanAddr;
        if (rdValid) begin
            bestCount <= newCount;
            bestBin <= newBin;
            if (curBin == '1) begin
                peakPixel <= curPix;
                peakBin <= newBin;
                peakCount <= newCount;
            end
        end
    end

endmodule

/* source/histSequencer.sv */
`timescale 1ns/1ns
`include "histo_macros.svh"

module histSequencer (
    input logic clk,
    input logic rst,
    input logic start,
    input logic sampleValid,
    input logic [`SAMPLE_W-1:0] sample,
    input logic ramReady,
    input logic updIdle,
    input logic scanDone,
    output logic ready,
    output logic busy,
    output logic scanSel,
    output logic updValid,
    output histPkg::addrT updAddr,
    output logic scanStart
);
    import histPkg::*;

    localparam int SAMP_W = $clog2(`DATA_NUM);
    localparam int ACQ_W = $clog2(`ACQ_NUM);

    seqState state;
    seqState nextState;

    // position in the frame, sample is innermost
    logic [SAMP_W-1:0] sampleCnt;
    pixT pixelCnt;
    logic [ACQ_W-1:0] acqCnt;

    logic accept;
    logic lastSample;
    logic busyQ;

    assign ready = (state == ACCUM);
    assign accept = sampleValid & ready;
    assign lastSample = (sampleCnt == SAMP_W'(`DATA_NUM - 1))
        && (pixelCnt == pixT'(`PIXEL_NUM - 1)) && (acqCnt == ACQ_W'(`ACQ_NUM - 1));

    // kick the scan once the pipeline has drained
    assign scanStart = (state == DRAIN) && updIdle;
    assign scanSel = (state == SCAN);
    // drops together with frameDone
    assign busy = busyQ & ~scanDone;

    always_comb begin
        nextState = state;
        case (state)
            CLEAR: if (ramReady) nextState = IDLE;
            IDLE: if (start) nextState = ACCUM;
            ACCUM: if (accept && lastSample) nextState = DRAIN;
            DRAIN: if (updIdle) nextState = SCAN;
            SCAN: if (scanDone) nextState = IDLE;
            default: nextState = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= CLEAR;
            busyQ <= 1'b0;
            updValid <= 1'b0;
            sampleCnt <= '0;
            pixelCnt <= '0;
            acqCnt <= '0;
        end else begin
            state <= nextState;
            busyQ <= (nextState != IDLE);
            updValid <= accept;
            if (state == IDLE) begin
                sampleCnt <= '0;
                pixelCnt <= '0;
                acqCnt <= '0;
            end else if (accept) begin
                // wrap sample, then pixel, then acquisition
                if (sampleCnt == SAMP_W'(`DATA_NUM - 1)) begin
                    sampleCnt <= '0;
                    if (pixelCnt == pixT'(`PIXEL_NUM - 1)) begin
                        pixelCnt <= '0;
                        acqCnt <= acqCnt + 1'b1;
                    end else begin
                        pixelCnt <= pixelCnt + 1'b1;
                    end
                end else begin
                    sampleCnt <= sampleCnt + 1'b1;
                end
            end
        end
    end

    // pixel index above the sample's top bits
    always_ff @(posedge clk) begin
        updAddr <= {pixelCnt, sample[`SAMPLE_W-1 -: `BIN_W]};
    end

endmodule

/* source/histTop.sv */
`timescale 1ns/1ns
`include "histo_macros.svh"

module histTop (
    input logic clk,
    input logic rst,
    input logic start,
    input logic sampleValid,
    input logic [`SAMPLE_W-1:0] sample,
    output logic ready,
    output logic busy,
    output logic peakValid,
    output logic frameDone,
    output histPkg::pixT peakPixel,
    output histPkg::binT peakBin,
    output histPkg::countT peakCount
);
    import histPkg::*;

    // sequencer to accumulate pipe
    logic updValid;
    addrT updAddr;
    logic updIdle;

    // scan handshake and memory ownership
    logic scanStart;
    logic scanSel;
    logic ramReady;

    memPort accPort ();
    memPort scanPort ();

    histSequencer seq (
        .clk(clk),
        .rst(rst),
        .start(start),
        .sampleValid(sampleValid),
        .sample(sample),
        .ramReady(ramReady),
        .updIdle(updIdle),
        .scanDone(frameDone),
        .ready(ready),
        .busy(busy),
        .scanSel(scanSel),
        .updValid(updValid),
        .updAddr(updAddr),
        .scanStart(scanStart)
    );

    binUpdater upd (
        .clk(clk),
        .rst(rst),
        .updValid(updValid),
        .updAddr(updAddr),
        .updIdle(updIdle),
        .mem(accPort.client)
    );

    // frame done is the scan done pulse
    peakFinder peak (
        .clk(clk),
        .rst(rst),
        .scanStart(scanStart),
        .scanDone(frameDone),
        .peakValid(peakValid),
        .peakPixel(peakPixel),
        .peakBin(peakBin),
        .peakCount(peakCount),
        .mem(scanPort.client)
    );

    histRam ram (
        .clk(clk),
        .rst(rst),
        .scanSel(scanSel),
        .ramReady(ramReady),
        .acc(accPort.memory),
        .scan(scanPort.memory)
    );

endmodule

/* tests/histTop_assert.sv */
`timescale 1ns/1ns
`include "histo_macros.svh"

module histTop_assert (
    input logic clk,
    input logic rst,
    input logic ready,
    input logic peakValid,
    input logic frameDone,
    input histPkg::pixT peakPixel
);
    import histPkg::*;

    // pixel expected on the next result strobe
    int nextPix;
    // read by the testbench top at the end of the run
    int failCount = 0;

    always_ff @(posedge clk) begin
        if (rst || frameDone) begin
            nextPix <= 0;
        end else if (peakValid) begin
            nextPix <= nextPix + 1;
        end
    end

    // no sample intake while results come out
    readyPeakExcl: assert property (@(posedge clk) disable iff (rst) !(ready && peakValid))
        else begin
            $error("ready and peakValid high in the same cycle");
            failCount++;
        end

    // ascending pixel order, at most PIXEL_NUM strobes
    peakOrder: assert property (@(posedge clk) disable iff (rst)
        peakValid |-> (nextPix < `PIXEL_NUM) && (peakPixel == pixT'(nextPix)))
        else begin
            $error("peak strobe out of order or too many strobes");
            failCount++;
        end

    // a frame ends only after all pixels reported
    peakTotal: assert property (@(posedge clk) disable iff (rst)
        frameDone |-> (nextPix == `PIXEL_NUM))
        else begin
            $error("frameDone without one strobe per pixel");
            failCount++;
        end

    // last strobe then frameDone, one cycle apart
    doneAfterLast: assert property (@(posedge clk) disable iff (rst)
        (peakValid && (peakPixel == pixT'(`PIXEL_NUM - 1))) |=> frameDone)
        else begin
            $error("frameDone missing after the last peak strobe");
            failCount++;
        end

    doneHasPeak: assert property (@(posedge clk) disable iff (rst)
        frameDone |-> $past(peakValid))
        else begin
            $error("frameDone not preceded by a peak strobe");
            failCount++;
        end

endmodule

bind histTop histTop_assert timingChecks (
    .clk(clk),
    .rst(rst),
    .ready(ready),
    .peakValid(peakValid),
    .frameDone(frameDone),
    .peakPixel(peakPixel)
);

/* tests/histChecker.sv */
`timescale 1ns/1ns
`include "histo_macros.svh"

module histChecker (
    input logic clk,
    input logic rst,
    input logic sampleValid,
    input logic [`SAMPLE_W-1:0] sample,
    input logic ready,
    input logic peakValid,
    input logic frameDone,
    input histPkg::pixT peakPixel,
    input histPkg::binT peakBin,
    input histPkg::countT peakCount,
    output int errCount,
    output int checkCount,
    output int frameCount
);
    import histPkg::*;

    localparam int COUNT_MAX = (1 << `COUNT_W) - 1;

    // accepted samples of the current frame, in arrival order
    logic [`SAMPLE_W-1:0] accepted [$];
    // next pixel to report
    int pixIdx;
    logic [`BIN_W+`COUNT_W-1:0] expected;
    binT expBin;
    countT expCount;

    // histogram of one pixel from the accepted samples, then its peak
    function automatic logic [`BIN_W+`COUNT_W-1:0] expectPeak(input int pix);
        int hist [`NBINS];
        int bestBin;
        int bestCount;
        int p;
        int b;
        for (b = 0; b < `NBINS; b++) begin
            hist[b] = 0;
        end
        foreach (accepted[i]) begin
            // order is acquisition, pixel, sample
            p = (i / `DATA_NUM) % `PIXEL_NUM;
            b = accepted[i] >> (`SAMPLE_W - `BIN_W);
            if ((p == pix) && (hist[b] < COUNT_MAX)) begin
                hist[b]++;
            end
        end
        // lowest bin wins a tie, empty pixel gives bin 0 count 0
        bestBin = 0;
        bestCount = 0;
        for (b = 0; b < `NBINS; b++) begin
            if (hist[b] > bestCount) begin
                bestCount = hist[b];
                bestBin = b;
            end
        end
        return {`BIN_W'(bestBin), `COUNT_W'(bestCount)};
    endfunction

    // mid-cycle, inputs and outputs settled
    always @(negedge clk) begin
        if (rst) begin
            accepted.delete();
            pixIdx = 0;
            errCount = 0;
            checkCount = 0;
            frameCount = 0;
        end else begin
            if (sampleValid && ready) begin
                accepted.push_back(sample);
            end
            if (peakValid) begin
                if (accepted.size() != `FRAME_LEN) begin
                    $display("error %0t: frame took %0d samples instead of %0d",
                        $time, accepted.size(), `FRAME_LEN);
                    errCount++;
                end
                expected = expectPeak(pixIdx);
                expBin = expected[`BIN_W+`COUNT_W-1:`COUNT_W];
                expCount = expected[`COUNT_W-1:0];
                if ((peakPixel != pixT'(pixIdx)) || (peakBin != expBin)
                    || (peakCount != expCount)) begin
                    $display("error %0t: pixel %0d bin %0d count %0d, expected %0d/%0d/%0d",
                        $time, peakPixel, peakBin, peakCount, pixIdx, expBin, expCount);
                    errCount++;
                end
                pixIdx++;
                checkCount++;
            end
            if (frameDone) begin
                if (pixIdx != `PIXEL_NUM) begin
                    $display("error %0t: %0d peak reports in the frame", $time, pixIdx);
                    errCount++;
                end
                accepted.delete();
                pixIdx = 0;
                frameCount++;
            end
        end
    end

endmodule

/* tests/histTb.sv */
`timescale 1ns/1ns
`include "histo_macros.svh"

module histTb;
    import histPkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int SEED = 49033;
    localparam int NUM_FRAMES = 6;
    // scan walk plus pipeline and strobe latency
    localparam int SCAN_LEN = `MEM_DEPTH + 4;
    localparam int SLACK = 200;
    localparam longint WATCHDOG_NS =
        2 * NUM_FRAMES * (`FRAME_LEN + SCAN_LEN + SLACK) * CLK_PERIOD;
    localparam int STALL_LIMIT = 16;
    localparam int DONE_LIMIT = SCAN_LEN + 32;
    localparam int STRAY_CYCLES = 8;
    // frame kinds
    localparam int MODE_RANDOM = 0;
    localparam int MODE_RUNS = 1;
    localparam int MODE_SAT = 2;
    localparam int MODE_STRAY = 3;
    // pixel that gets one bin flooded past the counter maximum
    localparam int SAT_PIXEL = 2;
    localparam int SAT_BIN = 5;

    logic clk = 1'b0;
    logic rst;
    logic start;
    logic sampleValid;
    logic [`SAMPLE_W-1:0] sample;
    logic ready;
    logic busy;
    logic peakValid;
    logic frameDone;
    pixT peakPixel;
    binT peakBin;
    countT peakCount;

    int tbErrors;
    int chkErrors;
    int chkCount;
    int frameCount;
    int assertErrors;
    int totalErrors;
    int frameNo;
    int seedVal;

    always #(CLK_PERIOD / 2) clk = ~clk;

    histTop UUT (
        .clk(clk),
        .rst(rst),
        .start(start),
        .sampleValid(sampleValid),
        .sample(sample),
        .ready(ready),
        .busy(busy),
        .peakValid(peakValid),
        .frameDone(frameDone),
        .peakPixel(peakPixel),
        .peakBin(peakBin),
        .peakCount(peakCount)
    );

    histChecker chk (
        .clk(clk),
        .rst(rst),
        .sampleValid(sampleValid),
        .sample(sample),
        .ready(ready),
        .peakValid(peakValid),
        .frameDone(frameDone),
        .peakPixel(peakPixel),
        .peakBin(peakBin),
        .peakCount(peakCount),
        .errCount(chkErrors),
        .checkCount(chkCount),
        .frameCount(frameCount)
    );

    // inputs change 2 ns after the rising edge
    task automatic stepCycle();
        @(posedge clk);
        #2;
    endtask

    // strobe that the engine must ignore
    task automatic driveStray();
        sample = `SAMPLE_W'($urandom);
        sampleValid = 1'b1;
    endtask

    function automatic logic [`SAMPLE_W-1:0] makeSample(input int mode, input int idx);
        logic [`SAMPLE_W-1:0] raw;
        logic [`BIN_W-1:0] bin;
        raw = `SAMPLE_W'($urandom);
        bin = raw[`SAMPLE_W-1 -: `BIN_W];
        if (mode == MODE_RUNS) begin
            // runs of 9 equal bins back to back
            bin = `BIN_W'(((idx / 9) * 5) % `NBINS);
        end else if ((mode == MODE_SAT) && ((idx / `DATA_NUM) % `PIXEL_NUM == SAT_PIXEL)) begin
            bin = `BIN_W'(SAT_BIN);
        end
        return {bin, raw[`SAMPLE_W-`BIN_W-1:0]};
    endfunction

    // busy rises with the clear sweep and falls in IDLE
    task automatic waitClear();
        int cnt;
        cnt = 0;
        while (!busy && (cnt < 8)) begin
            stepCycle();
            cnt++;
        end
        if (!busy) begin
            $display("busy did not rise for the memory clear sweep after reset");
            tbErrors++;
        end
        cnt = 0;
        while (busy && (cnt < `MEM_DEPTH + 8)) begin
            stepCycle();
            cnt++;
        end
        if (busy) begin
            $display("memory clear sweep did not finish after reset");
            tbErrors++;
        end
    endtask

    task automatic runFrame(input int mode);
        int idx;
        int stall;
        int cnt;
        logic busyDrop;
        idx = 0;
        stall = 0;
        busyDrop = 1'b0;
        frameNo++;
        if (mode == MODE_STRAY) begin
            for (cnt = 0; cnt < STRAY_CYCLES; cnt++) begin
                driveStray();
                stepCycle();
            end
        end
        if (ready || busy) begin
            $display("frame %0d: engine not idle before start", frameNo);
            tbErrors++;
        end
        sampleValid = 1'b0;
        start = 1'b1;
        stepCycle();
        start = 1'b0;
        if (!ready) begin
            $display("frame %0d: ready did not rise one cycle after start", frameNo);
            tbErrors++;
        end
        if (!busy) begin
            $display("frame %0d: busy did not rise one cycle after start", frameNo);
            tbErrors++;
        end
        // ready seen now holds at the next edge
        while ((idx < `FRAME_LEN) && (stall < STALL_LIMIT)) begin
            if (!ready) begin
                sampleValid = 1'b0;
                stall++;
            end else if ((mode == MODE_RANDOM || mode == MODE_STRAY) && (($urandom % 4) == 0)) begin
                sampleValid = 1'b0;
            end else begin
                sample = makeSample(mode, idx);
                sampleValid = 1'b1;
                idx++;
            end
            stepCycle();
        end
        if (idx < `FRAME_LEN) begin
            $display("frame %0d: ready dropped after %0d samples", frameNo, idx);
            tbErrors++;
        end
        if (ready) begin
            $display("frame %0d: ready still high after the last sample", frameNo);
            tbErrors++;
        end
        // strays during drain and scan in the stray frame
        cnt = 0;
        while (!frameDone && (cnt < DONE_LIMIT)) begin
            // busy stays up through drain and scan
            if (!busy && !busyDrop) begin
                $display("frame %0d: busy fell before frameDone", frameNo);
                tbErrors++;
                busyDrop = 1'b1;
            end
            if ((mode == MODE_STRAY) && (cnt < STRAY_CYCLES)) begin
                driveStray();
            end else begin
                sampleValid = 1'b0;
            end
            stepCycle();
            cnt++;
        end
        sampleValid = 1'b0;
        if (!frameDone) begin
            $display("frame %0d: frameDone never came", frameNo);
            tbErrors++;
        end else if (busy) begin
            $display("frame %0d: busy still high with frameDone", frameNo);
            tbErrors++;
        end
        stepCycle();
    endtask

    initial begin
        rst = 1'b1;
        start = 1'b0;
        sampleValid = 1'b0;
        sample = '0;
        tbErrors = 0;
        frameNo = 0;
        seedVal = $urandom(SEED);
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        waitClear();
        runFrame(MODE_RANDOM);
        runFrame(MODE_RUNS);
        runFrame(MODE_SAT);
        runFrame(MODE_STRAY);
        runFrame(MODE_RANDOM);
        runFrame(MODE_RUNS);
        repeat (4) stepCycle();
        if (frameCount != NUM_FRAMES) begin
            $display("only %0d of %0d frames completed", frameCount, NUM_FRAMES);
            tbErrors++;
        end
        assertErrors = UUT.timingChecks.failCount;
        totalErrors = tbErrors + chkErrors + assertErrors;
        $display("frames %0d, checks %0d, errors %0d (checker %0d, sequence %0d, assertions %0d)",
            frameCount, chkCount, totalErrors, chkErrors, tbErrors, assertErrors);
        if (totalErrors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // watchdog sized from frame, scan and slack lengths
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* sources.f */
+incdir+source
source/histPkg.sv
source/memPort.sv
source/histRam.sv
source/binUpdater.sv
source/peakFinder.sv
source/histSequencer.sv
source/histTop.sv
tests/histTop_assert.sv
tests/histChecker.sv
tests/histTb.sv

/* Bender.yml */
package:
  name: hist_engine

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/histPkg.sv
      - source/memPort.sv
      - source/histRam.sv
      - source/binUpdater.sv
      - source/peakFinder.sv
      - source/histSequencer.sv
      - source/histTop.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/histTop_assert.sv
      - tests/histChecker.sv
      - tests/histTb.sv
